// File: hw/host_pkg.sv
// ####################
// Host I/O package
// Widths, address map, opcodes and the
// message structs shared by every block
// ####################

`default_nettype none

package host_pkg;

  localparam int ADDR_W    = 16;
  localparam int DATA_W    = 32;
  localparam int MEM_WORDS = 256;
  localparam int NUM_CORE  = 4;
  localparam int TRACE_W   = 8;

  // Derived widths
  localparam int MEM_IDX_W  = $clog2(MEM_WORDS);
  localparam int CORE_IDX_W = $clog2(NUM_CORE);
  localparam int WORD_SHIFT = $clog2(DATA_W / 8);

  // Address map
  localparam logic [ADDR_W-1:0] HOST_BASE  = 16'h8000;
  localparam logic [ADDR_W-1:0] FINISH_OFS = 16'h0000;
  localparam logic [ADDR_W-1:0] TRACE_OFS  = 16'h0004;

  typedef enum logic {
    e_rd = 1'b0,
    e_wr = 1'b1
  } io_op_e;

  typedef enum logic {
    e_src_proc = 1'b0,
    e_src_ld   = 1'b1
  } src_e;

  typedef struct packed {
    io_op_e              op;
    logic [ADDR_W-1:0]   addr;
    src_e                src;
  } io_hdr_t;

  // Same layout for commands and responses
  typedef struct packed {
    io_hdr_t             hdr;
    logic [DATA_W-1:0]   data;
  } io_msg_t;

  typedef enum logic {
    e_nbf_write = 1'b0,
    e_nbf_end   = 1'b1
  } nbf_op_e;

  typedef struct packed {
    nbf_op_e             op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
  } nbf_rec_t;

endpackage

`default_nettype wire

// File: hw/nbf_loader.sv
// ####################
// Boot record loader
// Turns write records into memory write
// commands, flags done after the end record
// ####################

`timescale 1ns/100ps
`default_nettype none

module nbf_loader (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  host_pkg::nbf_rec_t rec_i,
  input  logic               rec_valid_i,
  output logic               rec_ready_o,
  output host_pkg::io_msg_t  cmd_o,
  output logic               cmd_valid_o,
  input  logic               cmd_ready_i,
  input  host_pkg::io_msg_t  resp_i,
  input  logic               resp_valid_i,
  output logic               done_o
);

  host_pkg::io_msg_t cmd_q;
  logic              cmd_valid_q;
  logic              seen_end_q;
  logic [3:0]        pending_q;
  logic              rec_fire;
  logic              cmd_fire;
  logic              resp_fire;

  // One record in flight, nothing taken after the end record
  assign rec_ready_o = !cmd_valid_q && !seen_end_q;
  assign rec_fire    = rec_valid_i && rec_ready_o;
  assign cmd_fire    = cmd_valid_q && cmd_ready_i;
  assign resp_fire   = resp_valid_i && (resp_i.hdr.op == host_pkg::e_wr);

  assign cmd_o       = cmd_q;
  assign cmd_valid_o = cmd_valid_q;
  assign done_o      = seen_end_q && (pending_q == '0);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      cmd_valid_q <= 1'b0;
      seen_end_q  <= 1'b0;
      pending_q   <= '0;
    end
    else
    begin
      if (rec_fire && (rec_i.op == host_pkg::e_nbf_write))
        cmd_valid_q <= 1'b1;
      else if (cmd_fire)
        cmd_valid_q <= 1'b0;

      if (rec_fire && (rec_i.op == host_pkg::e_nbf_end))
        seen_end_q <= 1'b1;

      // Writes issued but not yet answered
      case ({cmd_fire, resp_fire})
        2'b10:   pending_q <= pending_q + 4'd1;
        2'b01:   pending_q <= pending_q - 4'd1;
        default: pending_q <= pending_q;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rec_fire)
    begin
      cmd_q.hdr.op   <= host_pkg::e_wr;
      cmd_q.hdr.addr <= rec_i.addr;
      cmd_q.hdr.src  <= host_pkg::e_src_ld;
      cmd_q.data     <= rec_i.data;
    end
  end

endmodule

`default_nettype wire

// File: hw/io_crossbar.sv
// ####################
// I/O crossbar
// One transaction at a time from the loader or
// the processor, routed to memory or host regs
// ####################

`timescale 1ns/100ps
`default_nettype none

module io_crossbar (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  host_pkg::io_msg_t proc_cmd_i,
  input  logic              proc_cmd_valid_i,
  output logic              proc_cmd_ready_o,
  output host_pkg::io_msg_t proc_resp_o,
  output logic              proc_resp_valid_o,
  input  logic              proc_resp_ready_i,
  input  host_pkg::io_msg_t ld_cmd_i,
  input  logic              ld_cmd_valid_i,
  output logic              ld_cmd_ready_o,
  output host_pkg::io_msg_t ld_resp_o,
  output logic              ld_resp_valid_o,
  output host_pkg::io_msg_t mem_cmd_o,
  output logic              mem_cmd_valid_o,
  input  logic              mem_cmd_ready_i,
  input  host_pkg::io_msg_t mem_resp_i,
  input  logic              mem_resp_valid_i,
  output logic              mem_resp_ready_o,
  output host_pkg::io_msg_t reg_cmd_o,
  output logic              reg_cmd_valid_o,
  input  logic              reg_cmd_ready_i,
  input  host_pkg::io_msg_t reg_resp_i,
  input  logic              reg_resp_valid_i,
  output logic              reg_resp_ready_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_return
  } state_e;

  state_e            state_q;
  host_pkg::io_msg_t cmd_q;
  host_pkg::io_msg_t resp_q;
  host_pkg::io_msg_t grant_cmd;
  logic              to_reg_q;
  logic              resp_held_q;
  logic              accept;
  logic              tgt_cmd_fire;
  logic              tgt_resp_fire;
  logic              src_resp_fire;

  // Loader has fixed priority
  assign ld_cmd_ready_o   = (state_q == st_idle);
  assign proc_cmd_ready_o = (state_q == st_idle) && !ld_cmd_valid_i;
  assign accept           = (state_q == st_idle) && (ld_cmd_valid_i || proc_cmd_valid_i);

  always_comb
  begin
    grant_cmd         = ld_cmd_valid_i ? ld_cmd_i : proc_cmd_i;
    grant_cmd.hdr.src = ld_cmd_valid_i ? host_pkg::e_src_ld : host_pkg::e_src_proc;
  end

  assign mem_cmd_o       = cmd_q;
  assign reg_cmd_o       = cmd_q;
  assign mem_cmd_valid_o = (state_q == st_issue) && !to_reg_q;
  assign reg_cmd_valid_o = (state_q == st_issue) && to_reg_q;
  assign tgt_cmd_fire    = (mem_cmd_valid_o && mem_cmd_ready_i)
                        || (reg_cmd_valid_o && reg_cmd_ready_i);

  assign mem_resp_ready_o = (state_q == st_return) && !resp_held_q && !to_reg_q;
  assign reg_resp_ready_o = (state_q == st_return) && !resp_held_q && to_reg_q;
  assign tgt_resp_fire    = (mem_resp_valid_i && mem_resp_ready_o)
                         || (reg_resp_valid_i && reg_resp_ready_o);

  // Response goes back to whoever issued it
  assign proc_resp_o       = resp_q;
  assign ld_resp_o         = resp_q;
  assign proc_resp_valid_o = resp_held_q && (resp_q.hdr.src == host_pkg::e_src_proc);
  assign ld_resp_valid_o   = resp_held_q && (resp_q.hdr.src == host_pkg::e_src_ld);
  assign src_resp_fire     = ld_resp_valid_o || (proc_resp_valid_o && proc_resp_ready_i);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q     <= st_idle;
      resp_held_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        st_idle:
          if (accept)
            state_q <= st_issue;
        st_issue:
          if (tgt_cmd_fire)
            state_q <= st_return;
        st_return:
          if (tgt_resp_fire)
            resp_held_q <= 1'b1;
          else if (src_resp_fire)
          begin
            resp_held_q <= 1'b0;
            state_q     <= st_idle;
          end
        default:
          state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      cmd_q    <= grant_cmd;
      to_reg_q <= (grant_cmd.hdr.addr >= host_pkg::HOST_BASE);
    end
    if (tgt_resp_fire)
      resp_q <= to_reg_q ? reg_resp_i : mem_resp_i;
  end

endmodule

`default_nettype wire

// File: hw/host_regs.sv
// ####################
// Host control registers
// Sticky per-core finish bits and the
// trace-enable vector
// ####################

`timescale 1ns/100ps
`default_nettype none

module host_regs (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  host_pkg::io_msg_t             cmd_i,
  input  logic                          cmd_valid_i,
  output logic                          cmd_ready_o,
  output host_pkg::io_msg_t             resp_o,
  output logic                          resp_valid_o,
  input  logic                          resp_ready_i,
  output logic [host_pkg::NUM_CORE-1:0] finish_o,
  output logic [host_pkg::TRACE_W-1:0]  trace_en_o
);

  host_pkg::io_msg_t                   resp_q;
  logic                                resp_valid_q;
  logic [host_pkg::NUM_CORE-1:0]       finish_q;
  logic [host_pkg::TRACE_W-1:0]        trace_q;
  logic [host_pkg::ADDR_W-1:0]         ofs;
  logic [host_pkg::DATA_W-1:0]         rd_data;
  logic                                cmd_fire;
  logic                                is_write;

  assign cmd_ready_o  = !resp_valid_q;
  assign cmd_fire     = cmd_valid_i && cmd_ready_o;
  assign is_write     = (cmd_i.hdr.op == host_pkg::e_wr);
  assign ofs          = cmd_i.hdr.addr - host_pkg::HOST_BASE;

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;
  assign finish_o     = finish_q;
  assign trace_en_o   = trace_q;

  // Unused offsets read as zero
  always_comb
  begin
    rd_data = '0;
    if (ofs == host_pkg::FINISH_OFS)
      rd_data[host_pkg::NUM_CORE-1:0] = finish_q;
    else if (ofs == host_pkg::TRACE_OFS)
      rd_data[host_pkg::TRACE_W-1:0] = trace_q;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      resp_valid_q <= 1'b0;
      finish_q     <= '0;
      trace_q      <= '0;
    end
    else
    begin
      if (cmd_fire)
        resp_valid_q <= 1'b1;
      else if (resp_ready_i)
        resp_valid_q <= 1'b0;

      if (cmd_fire && is_write && (ofs == host_pkg::FINISH_OFS))
        finish_q[cmd_i.data[host_pkg::CORE_IDX_W-1:0]] <= 1'b1;
      if (cmd_fire && is_write && (ofs == host_pkg::TRACE_OFS))
        trace_q <= cmd_i.data[host_pkg::TRACE_W-1:0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_q.hdr  <= cmd_i.hdr;
      resp_q.data <= is_write ? cmd_i.data : rd_data;
    end
  end

endmodule

`default_nettype wire

// File: hw/mem_backing.sv
// ####################
// Backing memory
// Single-port word array, one command
// and one held response at a time
// ####################

`timescale 1ns/100ps
`default_nettype none

module mem_backing (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  host_pkg::io_msg_t cmd_i,
  input  logic              cmd_valid_i,
  output logic              cmd_ready_o,
  output host_pkg::io_msg_t resp_o,
  output logic              resp_valid_o,
  input  logic              resp_ready_i
);

  logic [host_pkg::DATA_W-1:0]    mem [host_pkg::MEM_WORDS];
  host_pkg::io_msg_t              resp_q;
  logic                           resp_valid_q;
  logic [host_pkg::MEM_IDX_W-1:0] idx;
  logic                           cmd_fire;
  logic                           is_write;

  assign cmd_ready_o  = !resp_valid_q;
  assign cmd_fire     = cmd_valid_i && cmd_ready_o;
  assign is_write     = (cmd_i.hdr.op == host_pkg::e_wr);

  // Byte address to word index, wraps at MEM_WORDS
  assign idx          = cmd_i.hdr.addr[host_pkg::WORD_SHIFT +: host_pkg::MEM_IDX_W];

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      resp_valid_q <= 1'b0;
    else if (cmd_fire)
      resp_valid_q <= 1'b1;
    else if (resp_ready_i)
      resp_valid_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_q.hdr <= cmd_i.hdr;
      if (is_write)
      begin
        mem[idx]    <= cmd_i.data;
        resp_q.data <= cmd_i.data;
      end
      else
        resp_q.data <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// File: hw/sim_host_top.sv
// ####################
// Host I/O top level
// Loader, crossbar, host regs and memory
// ####################

`timescale 1ns/100ps
`default_nettype none

module sim_host_top (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  host_pkg::io_msg_t             proc_cmd_i,
  input  logic                          proc_cmd_valid_i,
  output logic                          proc_cmd_ready_o,
  output host_pkg::io_msg_t             proc_resp_o,
  output logic                          proc_resp_valid_o,
  input  logic                          proc_resp_ready_i,
  input  host_pkg::nbf_rec_t            rec_i,
  input  logic                          rec_valid_i,
  output logic                          rec_ready_o,
  output logic                          load_done_o,
  output logic [host_pkg::NUM_CORE-1:0] finish_o,
  output logic [host_pkg::TRACE_W-1:0]  trace_en_o
);

  host_pkg::io_msg_t ld_cmd;
  logic              ld_cmd_valid;
  logic              ld_cmd_ready;
  host_pkg::io_msg_t ld_resp;
  logic              ld_resp_valid;

  host_pkg::io_msg_t mem_cmd;
  logic              mem_cmd_valid;
  logic              mem_cmd_ready;
  host_pkg::io_msg_t mem_resp;
  logic              mem_resp_valid;
  logic              mem_resp_ready;

  host_pkg::io_msg_t reg_cmd;
  logic              reg_cmd_valid;
  logic              reg_cmd_ready;
  host_pkg::io_msg_t reg_resp;
  logic              reg_resp_valid;
  logic              reg_resp_ready;

  nbf_loader u_loader (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rec_i        (rec_i),
    .rec_valid_i  (rec_valid_i),
    .rec_ready_o  (rec_ready_o),
    .cmd_o        (ld_cmd),
    .cmd_valid_o  (ld_cmd_valid),
    .cmd_ready_i  (ld_cmd_ready),
    .resp_i       (ld_resp),
    .resp_valid_i (ld_resp_valid),
    .done_o       (load_done_o)
  );

  io_crossbar u_xbar (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .proc_cmd_i        (proc_cmd_i),
    .proc_cmd_valid_i  (proc_cmd_valid_i),
    .proc_cmd_ready_o  (proc_cmd_ready_o),
    .proc_resp_o       (proc_resp_o),
    .proc_resp_valid_o (proc_resp_valid_o),
    .proc_resp_ready_i (proc_resp_ready_i),
    .ld_cmd_i          (ld_cmd),
    .ld_cmd_valid_i    (ld_cmd_valid),
    .ld_cmd_ready_o    (ld_cmd_ready),
    .ld_resp_o         (ld_resp),
    .ld_resp_valid_o   (ld_resp_valid),
    .mem_cmd_o         (mem_cmd),
    .mem_cmd_valid_o   (mem_cmd_valid),
    .mem_cmd_ready_i   (mem_cmd_ready),
    .mem_resp_i        (mem_resp),
    .mem_resp_valid_i  (mem_resp_valid),
    .mem_resp_ready_o  (mem_resp_ready),
    .reg_cmd_o         (reg_cmd),
    .reg_cmd_valid_o   (reg_cmd_valid),
    .reg_cmd_ready_i   (reg_cmd_ready),
    .reg_resp_i        (reg_resp),
    .reg_resp_valid_i  (reg_resp_valid),
    .reg_resp_ready_o  (reg_resp_ready)
  );

  host_regs u_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_i        (reg_cmd),
    .cmd_valid_i  (reg_cmd_valid),
    .cmd_ready_o  (reg_cmd_ready),
    .resp_o       (reg_resp),
    .resp_valid_o (reg_resp_valid),
    .resp_ready_i (reg_resp_ready),
    .finish_o     (finish_o),
    .trace_en_o   (trace_en_o)
  );

  mem_backing u_mem (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_i        (mem_cmd),
    .cmd_valid_i  (mem_cmd_valid),
    .cmd_ready_o  (mem_cmd_ready),
    .resp_o       (mem_resp),
    .resp_valid_o (mem_resp_valid),
    .resp_ready_i (mem_resp_ready)
  );

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
// ####################
// Testbench clock and reset
// 10 ns clock, reset low for 3 cycles
// ####################

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: verif/sim_host_checker.sv
// ####################
// Crossbar handshake checker
// Payload stability on held valids and
// one response per accepted command
// ####################

`timescale 1ns/100ps
`default_nettype none

module sim_host_checker (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              proc_cmd_vld_i,
  input logic              proc_cmd_rdy_i,
  input host_pkg::io_msg_t proc_resp_i,
  input logic              proc_resp_vld_i,
  input logic              proc_resp_rdy_i,
  input host_pkg::io_msg_t ld_cmd_i,
  input logic              ld_cmd_vld_i,
  input logic              ld_cmd_rdy_i,
  input logic              ld_resp_vld_i
);

  logic [1:0] proc_open_q;
  logic [1:0] ld_open_q;

  // Open commands per source
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      proc_open_q <= '0;
      ld_open_q   <= '0;
    end
    else
    begin
      proc_open_q <= proc_open_q + 2'(proc_cmd_vld_i && proc_cmd_rdy_i)
                   - 2'(proc_resp_vld_i && proc_resp_rdy_i);
      ld_open_q   <= ld_open_q + 2'(ld_cmd_vld_i && ld_cmd_rdy_i) - 2'(ld_resp_vld_i);
    end
  end

  proc_resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    proc_resp_vld_i && !proc_resp_rdy_i |=> proc_resp_vld_i && $stable(proc_resp_i))
    else $error("proc_resp payload changed or valid dropped while held");

  ld_cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ld_cmd_vld_i && !ld_cmd_rdy_i |=> ld_cmd_vld_i && $stable(ld_cmd_i))
    else $error("ld_cmd payload changed or valid dropped while held");

  proc_one_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    proc_resp_vld_i && proc_resp_rdy_i |-> proc_open_q == 2'd1)
    else $error("processor response without exactly one open command");

  ld_one_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ld_resp_vld_i |-> ld_open_q == 2'd1)
    else $error("loader response without exactly one open command");

endmodule

bind io_crossbar sim_host_checker u_chk (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .proc_cmd_vld_i  (proc_cmd_valid_i),
  .proc_cmd_rdy_i  (proc_cmd_ready_o),
  .proc_resp_i     (proc_resp_o),
  .proc_resp_vld_i (proc_resp_valid_o),
  .proc_resp_rdy_i (proc_resp_ready_i),
  .ld_cmd_i        (ld_cmd_i),
  .ld_cmd_vld_i    (ld_cmd_valid_i),
  .ld_cmd_rdy_i    (ld_cmd_ready_o),
  .ld_resp_vld_i   (ld_resp_valid_o)
);

`default_nettype wire

// File: verif/sim_host_tb.sv
// ####################
// Host I/O testbench
// LCG stimulus on the loader and processor ports,
// checked against a memory and register model
// ####################

`timescale 1ns/100ps
`default_nettype none

module sim_host_tb;

  localparam int N_LOAD  = 32;
  localparam int N_PLOAD = 40;
  localparam int N_RAND  = 300;
  localparam int N_TRANS = 256 + N_LOAD + 1 + N_PLOAD + N_LOAD + N_RAND + 40;

  logic                          clk;
  logic                          rst_n;
  host_pkg::io_msg_t             proc_cmd;
  logic                          proc_cmd_valid;
  logic                          proc_cmd_ready;
  host_pkg::io_msg_t             proc_resp;
  logic                          proc_resp_valid;
  logic                          proc_resp_ready;
  host_pkg::nbf_rec_t            rec;
  logic                          rec_valid;
  logic                          rec_ready;
  logic                          load_done;
  logic [host_pkg::NUM_CORE-1:0] finish;
  logic [host_pkg::TRACE_W-1:0]  trace_en;

  // Reference model
  logic [host_pkg::DATA_W-1:0]   model_mem [host_pkg::MEM_WORDS];
  logic [host_pkg::NUM_CORE-1:0] model_finish;
  logic [host_pkg::TRACE_W-1:0]  model_trace;

  logic [31:0] stim_seed;
  logic [31:0] ld_seed;
  logic [31:0] rdy_seed;
  logic        bp_on;
  int          cmd_count;
  int          resp_count;
  int          loaded_idx[$];

  tb_clk_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  sim_host_top DUT (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .proc_cmd_i        (proc_cmd),
    .proc_cmd_valid_i  (proc_cmd_valid),
    .proc_cmd_ready_o  (proc_cmd_ready),
    .proc_resp_o       (proc_resp),
    .proc_resp_valid_o (proc_resp_valid),
    .proc_resp_ready_i (proc_resp_ready),
    .rec_i             (rec),
    .rec_valid_i       (rec_valid),
    .rec_ready_o       (rec_ready),
    .load_done_o       (load_done),
    .finish_o          (finish),
    .trace_en_o        (trace_en)
  );

  function automatic logic [31:0] lcg(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    logic [7:0] i;
    i = idx[7:0];
    return {i, ~i, {i, i} ^ 16'hA5C3};
  endfunction

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  // One processor transaction checked against the model
  task automatic proc_access(input host_pkg::io_op_e op, input logic [15:0] addr,
                             input logic [31:0] data);
    host_pkg::io_msg_t cmd;
    host_pkg::io_msg_t resp;
    logic [31:0]       exp;
    int                idx;
    int                ofs;
    cmd.hdr.op   = op;
    cmd.hdr.addr = addr;
    cmd.hdr.src  = host_pkg::e_src_proc;
    cmd.data     = data;
    exp          = data;
    if (addr >= host_pkg::HOST_BASE)
    begin
      ofs = int'(addr - host_pkg::HOST_BASE);
      if (op == host_pkg::e_wr && ofs == int'(host_pkg::FINISH_OFS))
        model_finish[data % host_pkg::NUM_CORE] = 1'b1;
      else if (op == host_pkg::e_wr && ofs == int'(host_pkg::TRACE_OFS))
        model_trace = data[host_pkg::TRACE_W-1:0];
      else if (op == host_pkg::e_rd)
        exp = (ofs == int'(host_pkg::FINISH_OFS)) ? 32'(model_finish) :
              (ofs == int'(host_pkg::TRACE_OFS))  ? 32'(model_trace)  : 32'd0;
    end
    else
    begin
      idx = (int'(addr) / 4) % host_pkg::MEM_WORDS;
      if (op == host_pkg::e_wr)
        model_mem[idx] = data;
      else
        exp = model_mem[idx];
    end
    @(posedge clk);
    proc_cmd       <= cmd;
    proc_cmd_valid <= 1'b1;
    @(posedge clk);
    while (!proc_cmd_ready)
      @(posedge clk);
    proc_cmd_valid <= 1'b0;
    cmd_count++;
    @(posedge clk);
    while (!(proc_resp_valid && proc_resp_ready))
      @(posedge clk);
    resp = proc_resp;
    check_val("proc_resp_o.hdr", 64'(resp.hdr), 64'(cmd.hdr));
    check_val("proc_resp_o.data", 64'(resp.data), 64'(exp));
  endtask

  task automatic send_record(input host_pkg::nbf_rec_t r);
    @(posedge clk);
    rec       <= r;
    rec_valid <= 1'b1;
    forever
    begin
      @(posedge clk);
      check_val("load_done_o", 64'(load_done), 64'd0);
      if (rec_ready)
        break;
    end
    rec_valid <= 1'b0;
  endtask

  task automatic run_loader();
    host_pkg::nbf_rec_t r;
    int                 idx;
    int                 waited;
    for (int i = 0; i < N_LOAD; i++)
    begin
      ld_seed = lcg(ld_seed);
      idx     = int'(ld_seed[23:16]) % (host_pkg::MEM_WORDS / 2);
      ld_seed = lcg(ld_seed);
      r.op    = host_pkg::e_nbf_write;
      r.addr  = 16'(idx * 4);
      r.data  = ld_seed;
      send_record(r);
      model_mem[idx] = r.data;
      loaded_idx.push_back(idx);
    end
    r.op = host_pkg::e_nbf_end;
    send_record(r);
    waited = 0;
    while (!load_done)
    begin
      @(posedge clk);
      waited++;
      assert (waited < 200)
      else
      begin
        $display("load_done_o did not rise after the end record and all writes");
        stop_run();
      end
    end
  endtask

  // Processor stays in the upper half while the loader fills the lower half
  task automatic proc_load_traffic();
    int idx;
    for (int i = 0; i < N_PLOAD; i++)
    begin
      stim_seed = lcg(stim_seed);
      idx       = host_pkg::MEM_WORDS / 2 + int'(stim_seed[22:16]);
      stim_seed = lcg(stim_seed);
      proc_access(stim_seed[31] ? host_pkg::e_wr : host_pkg::e_rd, 16'(idx * 4), stim_seed);
    end
  endtask

  always @(posedge clk)
  begin
    rdy_seed = lcg(rdy_seed);
    proc_resp_ready <= bp_on ? (rdy_seed[21:20] != 2'b00) : 1'b1;
    if (proc_resp_valid && proc_resp_ready)
      resp_count++;
  end

  initial
  begin
    repeat (N_TRANS * 40) @(posedge clk);
    $display("Watchdog expired before the tests completed");
    stop_run();
  end

  initial
  begin
    proc_cmd        = '0;
    proc_cmd_valid  = 1'b0;
    proc_resp_ready = 1'b1;
    rec             = '0;
    rec_valid       = 1'b0;
    bp_on           = 1'b0;
    stim_seed       = 32'd34102;
    ld_seed         = lcg(32'd34102 ^ 32'h5555);
    rdy_seed        = lcg(32'd34102 ^ 32'hAAAA);
    model_finish    = '0;
    model_trace     = '0;
    cmd_count       = 0;
    resp_count      = 0;

    @(posedge clk);
    while (!rst_n)
      @(posedge clk);
    check_val("proc_resp_valid_o", 64'(proc_resp_valid), 64'd0);
    check_val("load_done_o", 64'(load_done), 64'd0);
    check_val("finish_o", 64'(finish), 64'd0);
    check_val("trace_en_o", 64'(trace_en), 64'd0);

    for (int i = 0; i < host_pkg::MEM_WORDS; i++)
      proc_access(host_pkg::e_wr, 16'(i * 4), fill_word(i));

    bp_on <= 1'b1;
    fork
      run_loader();
      proc_load_traffic();
    join
    foreach (loaded_idx[i])
      proc_access(host_pkg::e_rd, 16'(loaded_idx[i] * 4), 32'd0);

    // Address bits above the word index wrap onto the same word
    for (int i = 0; i < N_RAND; i++)
    begin
      stim_seed = lcg(stim_seed);
      proc_access(stim_seed[30] ? host_pkg::e_wr : host_pkg::e_rd,
                  stim_seed[31:16] & 16'h7FFC, lcg(stim_seed));
    end

    for (int i = 0; i < 6; i++)
    begin
      stim_seed = lcg(stim_seed);
      proc_access(host_pkg::e_wr, host_pkg::HOST_BASE + host_pkg::TRACE_OFS, stim_seed);
      check_val("trace_en_o", 64'(trace_en), 64'(model_trace));
      proc_access(host_pkg::e_rd, host_pkg::HOST_BASE + host_pkg::TRACE_OFS, 32'd0);
    end

    for (int i = 0; i < 8; i++)
    begin
      stim_seed = lcg(stim_seed);
      proc_access(host_pkg::e_wr, host_pkg::HOST_BASE + host_pkg::FINISH_OFS,
                  32'(stim_seed[25:24]));
      check_val("finish_o", 64'(finish), 64'(model_finish));
      proc_access(host_pkg::e_rd, host_pkg::HOST_BASE + host_pkg::FINISH_OFS, 32'd0);
    end

    proc_access(host_pkg::e_rd, host_pkg::HOST_BASE + 16'h0008, 32'd0);
    proc_access(host_pkg::e_rd, host_pkg::HOST_BASE + 16'h0100, 32'd0);
    proc_access(host_pkg::e_rd, 16'hFFFC, 32'd0);

    bp_on <= 1'b0;
    repeat (5) @(posedge clk);
    assert (resp_count == cmd_count)
    begin
      $display("PASS: all tests");
      $finish;
    end
    else
    begin
      $display("Fail at %0t: proc_resp_o count got %0d expected %0d",
               $time, resp_count, cmd_count);
      stop_run();
    end
  end

endmodule

`default_nettype wire

// File: compile.f
hw/host_pkg.sv
hw/nbf_loader.sv
hw/io_crossbar.sv
hw/host_regs.sv
hw/mem_backing.sv
hw/sim_host_top.sv
verif/tb_clk_gen.sv
verif/sim_host_checker.sv
verif/sim_host_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= sim_host_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
